// File: Makefile
# Verilator build for the MMU stage testbench

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= mmu_tb
RTL_TOP   ?= mmu_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_STR  ?= ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) src/mmu_cfg.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(BUILD_DIR)

// File: src/cp0_lite.sv
/*
 * Minimal CP0 register file for the MMU: Status, Config, EntryHi,
 * EntryLo and Index. There is no read-back port.
 * Status comes out of reset with ERL set and Config with every segment uncached.
 */
`include "mmu_cfg.svh"

module cp0_lite import mmu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cp0_we,
    input  cp0_sel_e    cp0_sel,
    input  logic [31:0] cp0_wdata,
    input  logic        tlbwi,
    output logic [31:0] status,
    output logic [31:0] config_r,
    output tlb_write_t  tlb_wr
);

    localparam logic [31:0] STATUS_RST = 32'd1 << `MMU_ERL_BIT;
    localparam logic [31:0] CONFIG_RST = (32'(`MMU_UNCACHED) << `MMU_K0_LSB)
                                       | (32'(`MMU_UNCACHED) << `MMU_KU_LSB)
                                       | (32'(`MMU_UNCACHED) << `MMU_K23_LSB);

    logic [`MMU_VPN_BITS-1:0]     entryhi_vpn;   // only the VPN is kept
    logic [31:0]                  entrylo;
    logic [`MMU_TLB_IDX_BITS-1:0] index_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            status      <= STATUS_RST;
            config_r    <= CONFIG_RST;
            entryhi_vpn <= '0;
            entrylo     <= '0;
            index_r     <= '0;
        end else if (cp0_we) begin
            case (cp0_sel)
                STATUS:  status      <= cp0_wdata;
                CONFIG:  config_r    <= cp0_wdata;
                ENTRYHI: entryhi_vpn <= cp0_wdata[31:`MMU_PAGE_BITS];
                ENTRYLO: entrylo     <= cp0_wdata;
                INDEX:   index_r     <= cp0_wdata[`MMU_TLB_IDX_BITS-1:0];
                default: ;
            endcase
        end
    end

    // tlbwi command, written by the tlb at the next edge
    always_comb begin
        tlb_wr.we           = tlbwi;
        tlb_wr.idx          = index_r;
        tlb_wr.entry.valid  = entrylo[`MMU_LO_V_BIT];
        tlb_wr.entry.vpn    = entryhi_vpn;
        tlb_wr.entry.pfn    = entrylo[`MMU_LO_PFN_LSB +: `MMU_PFN_BITS];
        tlb_wr.entry.cached = entrylo[`MMU_LO_C_LSB +: 3] == `MMU_CACHEABLE;
        tlb_wr.entry.dirty  = entrylo[`MMU_LO_D_BIT];
    end

endmodule

// File: src/mmu.sv
/*
 * Data-side segment decoder and address translator, purely combinational.
 * kseg0/kseg1 map directly, kuseg and kseg2/3 go through the tlb unless ERL
 * is set. A store to a clean page raises modified, and no address-error checks.
 */
`include "mmu_cfg.svh"

module mmu import mmu_pkg::*; (
    input  logic        en,
    input  logic [3:0]  wen,
    input  logic [31:0] vaddr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    input  logic        exc_flag,
    input  logic [31:0] status,
    input  logic [31:0] config_r,
    output tlb_req_t    tlb_req,
    input  tlb_resp_t   tlb_resp,
    output mem_req_t    mem_req,
    input  logic [31:0] bus_rdata,
    input  logic        bus_streq,
    output mmu_exc_t    exc,
    output logic        stallreq
);

    logic seg_mapped;
    logic direct_cached;
    logic use_tlb;
    logic tlb_streq;
    logic store;

    always_comb begin
        seg_mapped    = 1'b0;
        direct_cached = 1'b0;
        casez (vaddr[31:29])
            `MMU_SEG_KSEG0:  direct_cached = config_r[`MMU_K0_LSB +: 3] == `MMU_CACHEABLE;
            `MMU_SEG_KSEG1:  direct_cached = 1'b0;   // always uncached
            `MMU_SEG_KSEG23: seg_mapped    = 1'b1;
            default:         seg_mapped    = 1'b1;   // kuseg
        endcase
    end

    assign use_tlb = seg_mapped && !status[`MMU_ERL_BIT];  // ERL forces direct path
    assign store   = wen != 4'b0000;

    assign rdata    = en ? bus_rdata : 32'd0;
    assign stallreq = bus_streq || tlb_streq;

    always_comb begin
        tlb_req        = '0;
        exc            = '0;
        tlb_streq      = 1'b0;
        mem_req.en     = 1'b0;
        mem_req.wen    = en ? wen : 4'b0000;
        mem_req.paddr  = 32'd0;
        mem_req.cached = 1'b0;
        mem_req.wdata  = wdata;

        if (en && !exc_flag) begin
            if (!use_tlb) begin
                mem_req.en     = 1'b1;
                mem_req.paddr  = {3'b000, vaddr[28:0]};
                mem_req.cached = direct_cached;    // low for ERL fallback
            end else begin
                tlb_req.en    = 1'b1;
                tlb_req.vaddr = vaddr;
                tlb_req.refs  = store;
                tlb_streq     = !tlb_resp.rdy;     // wait out the lookup
                if (tlb_resp.rdy) begin
                    if (!tlb_resp.hit) begin
                        exc.refill   = 1'b1;
                        exc.badvaddr = vaddr;
                    end else if (store && !tlb_resp.dirty) begin
                        exc.modified = 1'b1;       // clean page
                        exc.badvaddr = vaddr;
                    end else begin
                        mem_req.en     = 1'b1;
                        mem_req.paddr  = tlb_resp.paddr;
                        mem_req.cached = tlb_resp.cached;
                    end
                end
            end
        end
    end

endmodule

// File: src/mmu_cfg.svh
/*
 * MMU sizing, segment codes and CP0 field positions.
 * Page size is fixed at 4 KB, so VPN and PFN are both 20 bits.
 * Changing the entry count also requires changing the index width.
 */
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

`define MMU_TLB_ENTRIES   8
`define MMU_TLB_IDX_BITS  3

`define MMU_PAGE_BITS     12
`define MMU_VPN_BITS      (32 - `MMU_PAGE_BITS)
`define MMU_PFN_BITS      (32 - `MMU_PAGE_BITS)

`define MMU_SEG_KSEG0     3'b100
`define MMU_SEG_KSEG1     3'b101
`define MMU_SEG_KSEG23    3'b11?

`define MMU_ERL_BIT       2
`define MMU_K0_LSB        0
`define MMU_KU_LSB        25
`define MMU_K23_LSB       28
`define MMU_CACHEABLE     3'd3
`define MMU_UNCACHED      3'd2

`define MMU_LO_PFN_LSB    6
`define MMU_LO_C_LSB      3
`define MMU_LO_D_BIT      2
`define MMU_LO_V_BIT      1

`endif

// File: src/mmu_pkg.sv
/*
 * Shared types of the data-side MMU.
 * The tlb response carries the entry's cached and dirty bits
 * next to the translated address.
 */
`include "mmu_cfg.svh"

package mmu_pkg;

    typedef struct packed {
        logic                      valid;
        logic [`MMU_VPN_BITS-1:0]  vpn;
        logic [`MMU_PFN_BITS-1:0]  pfn;
        logic                      cached;
        logic                      dirty;   // page is writable
    } tlb_entry_t;

    typedef struct packed {
        logic        en;
        logic [31:0] vaddr;
        logic        refs;                  // store access
    } tlb_req_t;

    typedef struct packed {
        logic        rdy;
        logic        hit;
        logic [31:0] paddr;
        logic        cached;
        logic        dirty;
    } tlb_resp_t;

    typedef struct packed {
        logic                         we;
        logic [`MMU_TLB_IDX_BITS-1:0] idx;
        tlb_entry_t                   entry;
    } tlb_write_t;

    typedef struct packed {
        logic        en;
        logic [3:0]  wen;
        logic [31:0] paddr;
        logic        cached;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        refill;
        logic        modified;
        logic [31:0] badvaddr;
    } mmu_exc_t;

    typedef enum logic [2:0] {
        STATUS  = 3'd0,
        CONFIG  = 3'd1,
        ENTRYHI = 3'd2,
        ENTRYLO = 3'd3,
        INDEX   = 3'd4
    } cp0_sel_e;

endpackage

// File: src/mmu_top.sv
/*
 * Data-side MMU stage: CP0 registers, tlb and segment decoder.
 * The core must hold its inputs while stallreq is high.
 * tlbwi is a one-cycle pulse, and the entry is written at the next edge.
 */
module mmu_top import mmu_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        en,
    input  logic [3:0]  wen,
    input  logic [31:0] vaddr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    input  logic        exc_flag,

    input  logic        cp0_we,
    input  cp0_sel_e    cp0_sel,
    input  logic [31:0] cp0_wdata,
    input  logic        tlbwi,

    output mem_req_t    mem_req,
    input  logic [31:0] bus_rdata,
    input  logic        bus_streq,

    output mmu_exc_t    exc,
    output logic        stallreq
);

    logic [31:0] status;
    logic [31:0] config_r;
    tlb_write_t  tlb_wr;
    tlb_req_t    tlb_req;
    tlb_resp_t   tlb_resp;

    cp0_lite i_cp0_lite (
        .clk       (clk),
        .rst       (rst),
        .cp0_we    (cp0_we),
        .cp0_sel   (cp0_sel),
        .cp0_wdata (cp0_wdata),
        .tlbwi     (tlbwi),
        .status    (status),
        .config_r  (config_r),
        .tlb_wr    (tlb_wr)
    );

    tlb i_tlb (
        .clk  (clk),
        .rst  (rst),
        .req  (tlb_req),
        .resp (tlb_resp),
        .wr   (tlb_wr)
    );

    mmu i_mmu (
        .en        (en),
        .wen       (wen),
        .vaddr     (vaddr),
        .wdata     (wdata),
        .rdata     (rdata),
        .exc_flag  (exc_flag),
        .status    (status),
        .config_r  (config_r),
        .tlb_req   (tlb_req),
        .tlb_resp  (tlb_resp),
        .mem_req   (mem_req),
        .bus_rdata (bus_rdata),
        .bus_streq (bus_streq),
        .exc       (exc),
        .stallreq  (stallreq)
    );

endmodule

// File: src/tlb.sv
/*
 * Fully associative TLB with 4 KB pages and no ASID.
 * The lookup is registered, and rdy is high only while the live request
 * still has the registered page and access kind. A write drops the result.
 * If several entries match, the lowest index wins.
 */
`include "mmu_cfg.svh"

module tlb import mmu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  tlb_req_t   req,
    output tlb_resp_t  resp,
    input  tlb_write_t wr
);

    localparam int PAGE_W = `MMU_PAGE_BITS;
    localparam int VPN_W  = `MMU_VPN_BITS;
    localparam int PFN_W  = `MMU_PFN_BITS;

    tlb_entry_t                  entries [`MMU_TLB_ENTRIES];
    logic [`MMU_TLB_ENTRIES-1:0] written;      // loaded since reset

    logic [VPN_W-1:0] req_vpn;
    logic             match_any;
    tlb_entry_t       match_entry;

    // registered lookup result
    logic             look_vld;
    logic             look_hit;
    logic [PFN_W-1:0] look_pfn;
    logic             look_cached;
    logic             look_dirty;
    logic [VPN_W-1:0] look_vpn;
    logic             look_refs;
    logic             page_match;

    assign req_vpn = req.vaddr[31:PAGE_W];

    // entry storage, payload only
    always_ff @(posedge clk) begin
        if (wr.we) begin
            entries[wr.idx] <= wr.entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            written <= '0;
        end else if (wr.we) begin
            written[wr.idx] <= 1'b1;
        end
    end

    // scan from the top so the lowest matching index ends up selected
    always_comb begin
        match_any   = 1'b0;
        match_entry = '0;
        for (int i = `MMU_TLB_ENTRIES - 1; i >= 0; i--) begin
            if (written[i] && entries[i].valid && entries[i].vpn == req_vpn) begin
                match_any   = 1'b1;
                match_entry = entries[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            look_vld <= 1'b0;
            look_hit <= 1'b0;
        end else if (wr.we) begin
            look_vld <= 1'b0;                  // no stale hit after tlbwi
        end else if (req.en) begin
            look_vld <= 1'b1;
            look_hit <= match_any;
        end
    end

    always_ff @(posedge clk) begin
        if (req.en) begin
            look_pfn    <= match_entry.pfn;
            look_cached <= match_entry.cached;
            look_dirty  <= match_entry.dirty;
            look_vpn    <= req_vpn;
            look_refs   <= req.refs;
        end
    end

    assign page_match = (look_vpn == req_vpn) && (look_refs == req.refs);

    // offset taken live, a repeated page may use another word
    always_comb begin
        resp.rdy    = look_vld && req.en && page_match;
        resp.hit    = look_hit;
        resp.paddr  = {look_pfn, req.vaddr[PAGE_W-1:0]};
        resp.cached = look_cached;
        resp.dirty  = look_dirty;
    end

endmodule

// File: verification/mmu_props.sv
/*
 * Concurrent checks on the MMU stage, bound into mmu_top.
 * Assumes the core holds its inputs while stallreq is high.
 */
module mmu_props import mmu_pkg::*; (
    input logic        clk,
    input logic        rst,
    input mem_req_t    mem_req,
    input mmu_exc_t    exc,
    input logic        stallreq,
    input logic        bus_streq,
    input logic [31:0] status,
    input tlb_req_t    tlb_req,
    input tlb_resp_t   tlb_resp
);

    // a bus request and an exception never go out together
    req_or_exc: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.en && (exc.refill || exc.modified)))
        else $error("bus request issued together with an exception");

    idle_after_reset: assert property (@(posedge clk)
        $past(rst) && !rst |-> !mem_req.en && !stallreq)
        else $error("bus request or stall right after reset");

    // lookup answers one cycle after a held request
    tlb_one_cycle: assert property (@(posedge clk) disable iff (rst)
        tlb_req.en && !status[2] && !tlb_resp.rdy |=>
            tlb_resp.rdy || !tlb_req.en || $changed(tlb_req))
        else $error("tlb lookup not ready one cycle after request");

    stable_under_stall: assert property (@(posedge clk) disable iff (rst)
        bus_streq && mem_req.en |=> $stable(mem_req))
        else $error("bus request changed while the bus stalled");

endmodule

bind mmu_top mmu_props i_mmu_props (.*);

// File: verification/mmu_tb.sv
/*
 * Testbench for mmu_top, driven by verification/mmu_tests.txt.
 * Run from the project root so the test file path resolves.
 * Expected results come from a reference model, the file values are cross-checked.
 */
`include "mmu_cfg.svh"

module mmu_tb import mmu_pkg::*; ;

    logic clk = 1'b0;
    logic rst, en, exc_flag, cp0_we, tlbwi, bus_streq, stallreq;
    logic [3:0] wen;
    logic [31:0] vaddr, wdata, rdata, cp0_wdata, bus_rdata;
    cp0_sel_e cp0_sel;
    mem_req_t mem_req;
    mmu_exc_t exc;

    // reference model state
    tlb_entry_t model_tlb [`MMU_TLB_ENTRIES];
    logic [31:0] m_status, m_config, m_hi, m_lo, m_index;
    logic look_vld, look_refs;
    logic [19:0] look_vpn;
    int errors, tests;
    logic test_bad, aborted;

    always #4 clk = ~clk;

    mmu_top i_mmu_top (.*);

    task check_mem(input mem_req_t got, input mem_req_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s mem_req got %h expected %h", $time, what, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task check_exc(input mmu_exc_t got, input mmu_exc_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: exc got %h expected %h", $time, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task check_data(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: rdata got %h expected %h", $time, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task report_problem(input string msg);
        $display("%s (at %0t)", msg, $time);
        errors++;
        test_bad = 1'b1;
    endtask

    task write_cp0(input int sel, input logic [31:0] value);
        @(negedge clk);
        en        = 1'b0;
        cp0_we    = 1'b1;
        cp0_sel   = cp0_sel_e'(sel);
        cp0_wdata = value;
        @(negedge clk);
        cp0_we = 1'b0;
        case (sel)
            0: m_status = value;
            1: m_config = value;
            2: m_hi = value;
            3: m_lo = value;
            4: m_index = value;
            default: ;
        endcase
    endtask

    task write_tlb;
        tlb_entry_t e;
        @(negedge clk);
        en    = 1'b0;
        tlbwi = 1'b1;
        @(negedge clk);
        tlbwi    = 1'b0;
        e.valid  = m_lo[1];
        e.vpn    = m_hi[31:12];
        e.pfn    = m_lo[25:6];
        e.cached = m_lo[5:3] == 3'd3;        // MIPS C field 3 is cacheable
        e.dirty  = m_lo[2];
        model_tlb[m_index[2:0]] = e;
        look_vld = 1'b0;
    endtask

    task run_access(input logic [3:0] a_wen, input logic [31:0] a_va,
                    input logic [31:0] a_wd, input logic a_xf, input logic a_stall,
                    input string f_kind, input logic [31:0] f_pa, input logic f_c);
        logic mapped, use_tlb, store, hit, exp_stall, saw_stall, prev_hold;
        string kind;
        logic [31:0] pa;
        logic cached;
        int stall_left, cycles;
        mem_req_t exp_mem, prev_mem;
        mmu_exc_t exp_exc;
        mapped = !(a_va[31:29] == 3'b100 || a_va[31:29] == 3'b101);
        use_tlb = mapped && !m_status[`MMU_ERL_BIT];
        store = a_wen != 4'd0;
        kind = "BUS";
        pa = {3'b000, a_va[28:0]};
        cached = (a_va[31:29] == 3'b100) && (m_config[2:0] == 3'd3);
        if (use_tlb) begin
            hit = 1'b0;
            for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
                if (!hit && model_tlb[i].valid && model_tlb[i].vpn == a_va[31:12]) begin
                    hit = 1'b1;
                    pa = {model_tlb[i].pfn, a_va[11:0]};
                    cached = model_tlb[i].cached;
                    if (store && !model_tlb[i].dirty) kind = "MOD";
                end
            end
            if (!hit) kind = "REFILL";
        end
        if (a_xf) kind = "NONE";
        if (kind != "BUS") begin
            pa = 32'd0;
            cached = 1'b0;
        end
        if (kind != f_kind || pa !== f_pa || cached !== f_c)
            report_problem("test file expectation disagrees with the reference model");
        exp_stall = use_tlb && !a_xf &&
                    !(look_vld && look_vpn == a_va[31:12] && look_refs == store);
        exp_mem = '{en: kind == "BUS", wen: a_wen, paddr: pa, cached: cached, wdata: a_wd};
        exp_exc = '0;
        exp_exc.refill = kind == "REFILL";
        exp_exc.modified = kind == "MOD";
        if (kind == "REFILL" || kind == "MOD") exp_exc.badvaddr = a_va;

        @(negedge clk);
        en = 1'b1;
        wen = a_wen;
        vaddr = a_va;
        wdata = a_wd;
        exc_flag = a_xf;
        bus_rdata = $urandom;
        stall_left = a_stall ? int'(2 + $urandom % 2) : 0;
        bus_streq = stall_left > 0;
        cycles = 0;
        saw_stall = 1'b0;
        prev_hold = 1'b0;
        #1;
        while (stallreq && cycles < 20) begin
            if (!bus_streq) saw_stall = 1'b1;    // lookup stall
            if (prev_hold) check_mem(mem_req, prev_mem, "stalled");
            prev_hold = bus_streq && mem_req.en;
            prev_mem = mem_req;
            @(negedge clk);
            if (stall_left > 0) stall_left--;
            bus_streq = stall_left > 0;
            cycles++;
            #1;
        end
        if (stallreq) begin
            report_problem("access timed out waiting for stall to clear");
            aborted = 1'b1;
        end else begin
            if (prev_hold) check_mem(mem_req, prev_mem, "after stall");
            if (!a_stall && saw_stall != exp_stall)
                report_problem(exp_stall ? "expected a lookup stall cycle, none seen"
                                         : "unexpected lookup stall on a repeated page");
            check_mem(mem_req, exp_mem, "final");
            check_exc(exc, exp_exc);
            check_data(rdata, bus_rdata);
        end
        if (use_tlb && !a_xf) begin
            look_vld = 1'b1;
            look_vpn = a_va[31:12];
            look_refs = store;
        end
        @(negedge clk);
        en = 1'b0;
        bus_streq = 1'b0;
    endtask

    initial begin
        int fd, sel, xf, stl, c, n;
        string line;
        logic [31:0] v1, v2, v3, v4;
        logic [47:0] kind_s;
        void'($urandom(20546));
        rst = 1'b1;
        en = 1'b0;
        wen = 4'd0;
        vaddr = 32'd0;
        wdata = 32'd0;
        exc_flag = 1'b0;
        cp0_we = 1'b0;
        cp0_sel = STATUS;
        cp0_wdata = 32'd0;
        tlbwi = 1'b0;
        bus_rdata = 32'd0;
        bus_streq = 1'b0;
        errors = 0;
        tests = 0;
        aborted = 1'b0;
        m_status = 32'h4;                    // ERL set
        m_config = 32'h2400_0002;            // every field uncached
        m_hi = '0;
        m_lo = '0;
        m_index = '0;
        look_vld = 1'b0;
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) model_tlb[i] = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("verification/mmu_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file");
            errors++;
        end else begin
            while (!aborted && $fgets(line, fd)) begin
                if (line.len() < 2 || line.getc(0) == "#") continue;
                test_bad = 1'b0;
                c = line.getc(0);
                if (c == "C") begin
                    n = $sscanf(line, "C %d %h", sel, v1);
                    if (n != 2) report_problem("malformed CP0 line in test file");
                    else write_cp0(sel, v1);
                end else if (c == "T") begin
                    write_tlb();
                end else begin
                    n = $sscanf(line, "A %h %h %h %d %d %s %h %h",
                                v1, v2, v3, xf, stl, kind_s, v4, c);
                    if (n != 8) report_problem("malformed access line in test file");
                    else run_access(v1[3:0], v2, v3, xf[0], stl[0],
                                    string'(kind_s), v4, c[0]);
                end
                tests++;
                $display("test %0d %s: %s", tests, line.substr(0, line.len() - 2),
                         test_bad ? "failed" : "ok");
            end
            $fclose(fd);
        end
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verification/mmu_tests.txt
# C sel value | T | A wen vaddr wdata exc_flag rand_stall kind paddr cached
# sel: 0 Status 1 Config 2 EntryHi 3 EntryLo 4 Index, all numbers hex except flags
A 0 00001234 00000000 0 0 BUS 00001234 0
A f 80000010 deadbeef 0 0 BUS 00000010 0
A 0 c0000020 00000000 0 0 BUS 00000020 0
A 0 a0400004 00000000 0 0 BUS 00400004 0
C 1 00000003
A 0 80000100 00000000 0 0 BUS 00000100 1
A 0 a0000100 00000000 0 0 BUS 00000100 0
C 0 00000000
C 2 00400000
C 3 000048de
C 4 00000001
T
A 0 00400abc 00000000 0 0 BUS 00123abc 1
A 0 00400ff0 00000000 0 0 BUS 00123ff0 1
A f 00400010 11223344 0 0 BUS 00123010 1
C 2 00500000
C 3 0001ddd2
C 4 00000002
T
A 0 00500008 00000000 0 0 BUS 00777008 0
A 3 00500008 cafe0000 0 0 MOD 00000000 0
A 0 00600000 00000000 0 0 REFILL 00000000 0
A f 7ffff000 12345678 0 0 REFILL 00000000 0
C 2 c0001000
C 3 0002af1e
C 4 00000005
T
A f c0001100 55aa55aa 0 1 BUS 00abc100 1
A 0 00400004 00000000 0 1 BUS 00123004 1
A 0 00400004 00000000 1 0 NONE 00000000 0
A f 80000040 01010101 0 1 BUS 00000040 1

// File: verilog.f
+incdir+src
src/mmu_pkg.sv
src/cp0_lite.sv
src/tlb.sv
src/mmu.sv
src/mmu_top.sv
verification/mmu_props.sv
verification/mmu_tb.sv
